/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpuTop
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR)

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic [wordSize-1:0] opA,
    input  logic [wordSize-1:0] opB,
    input  aluOpE               aluOp,
    input  opcodeE              branchOp,
    output logic [wordSize-1:0] result,
    output logic                branchTaken
);

    always_comb begin
        case (aluOp)
            ALU_ADD: result = opA + opB;
            ALU_SUB: result = opA - opB;
            ALU_AND: result = opA & opB;
            ALU_ORR: result = opA | opB;
            ALU_NOT: result = ~opA;
            ALU_TCP: result = ~opA + 1'b1;
            ALU_SHL: result = {opA[wordSize-2:0], 1'b0};
            ALU_SHR: result = {opA[wordSize-1], opA[wordSize-1:1]}; // arithmetic
            ALU_LHI: result = {opB[immW-1:0], {(wordSize-immW){1'b0}}};
            default: result = opB;
        endcase
    end

    always_comb begin
        case (branchOp)
            BNE:     branchTaken = (opA != opB);
            BEQ:     branchTaken = (opA == opB);
            BGZ:     branchTaken = ($signed(opA) > 16'sd0);
            BLZ:     branchTaken = ($signed(opA) < 16'sd0);
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic [wordSize-1:0] instr,
    output logic                regWrite,
    output logic                aluSrcImm,
    output logic                memRead,
    output logic                memWrite,
    output logic                isBranch,
    output logic                isJump,
    output logic                isWwd,
    output logic                isHalt,
    output logic                usesRs,
    output logic                usesRt,
    output aluOpE               aluOp,
    output wbSelE               wbSel,
    output logic [regAddrW-1:0] destReg
);

    opcodeE opcode;
    functE  funct;

    assign opcode = opcodeE'(instr[opLsb +: opW]);
    assign funct  = functE'(instr[functW-1:0]);

    always_comb begin
        regWrite  = 1'b0;
        aluSrcImm = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        isBranch  = 1'b0;
        isJump    = 1'b0;
        isWwd     = 1'b0;
        isHalt    = 1'b0;
        usesRs    = 1'b0;
        usesRt    = 1'b0;
        aluOp     = ALU_PASSB;
        wbSel     = WB_ALU;
        destReg   = instr[rtLsb +: regAddrW]; // I-type and loads write rt
        case (opcode)
            ADI, ORI: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                usesRs    = 1'b1;
                aluOp     = (opcode == ADI) ? ALU_ADD : ALU_ORR;
            end
            LHI: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluOp     = ALU_LHI;
            end
            LWD, SWD: begin
                aluSrcImm = 1'b1;
                usesRs    = 1'b1;
                aluOp     = ALU_ADD; // address is rs + imm
                regWrite  = (opcode == LWD);
                memRead   = (opcode == LWD);
                memWrite  = (opcode == SWD);
                usesRt    = (opcode == SWD); // store data
                if (opcode == LWD) wbSel = WB_MEM;
            end
            BNE, BEQ, BGZ, BLZ: begin
                isBranch = 1'b1;
                usesRs   = 1'b1;
                usesRt   = (opcode == BNE) || (opcode == BEQ);
            end
            JMP: isJump = 1'b1;
            RTYPE: begin
                destReg = instr[rdLsb +: regAddrW];
                case (funct)
                    ADD:     aluOp = ALU_ADD;
                    SUB:     aluOp = ALU_SUB;
                    AND:     aluOp = ALU_AND;
                    ORR:     aluOp = ALU_ORR;
                    NOT:     aluOp = ALU_NOT;
                    TCP:     aluOp = ALU_TCP;
                    SHL:     aluOp = ALU_SHL;
                    SHR:     aluOp = ALU_SHR;
                    default: aluOp = ALU_PASSB;
                endcase
                regWrite = (aluOp != ALU_PASSB);
                usesRt   = (funct == ADD) || (funct == SUB) || (funct == AND) || (funct == ORR);
                usesRs   = regWrite || (funct == WWD);
                isWwd    = (funct == WWD);
                isHalt   = (funct == HLT);
            end
            default: ; // unsupported opcodes act as nops
        endcase
    end

endmodule

`default_nettype wire

/* cpuCtrlPkg.sv */
`default_nettype none

package cpuCtrlPkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_ORR,
        ALU_NOT,
        ALU_TCP,
        ALU_SHL,
        ALU_SHR,
        ALU_LHI,
        ALU_PASSB
    } aluOpE;

    typedef enum logic {
        WB_ALU,
        WB_MEM
    } wbSelE;

    typedef enum logic [1:0] {
        RUN,
        DRAIN,
        HALTED
    } pipeStateE;

endpackage

`default_nettype wire

/* cpuIsaPkg.sv */
`default_nettype none

package cpuIsaPkg;

    localparam int wordSize = 16;
    localparam int numRegs = 4;
    localparam int regAddrW = $clog2(numRegs);

    // instruction word layout
    localparam int opW = 4;
    localparam int opLsb = 12;
    localparam int rsLsb = 10;
    localparam int rtLsb = 8;
    localparam int rdLsb = 6;
    localparam int functW = 6;
    localparam int immW = 8;
    localparam int targetW = 12;

    typedef enum logic [opW-1:0] {
        BNE   = 4'd0,
        BEQ   = 4'd1,
        BGZ   = 4'd2,
        BLZ   = 4'd3,
        ADI   = 4'd4,
        ORI   = 4'd5,
        LHI   = 4'd6,
        LWD   = 4'd7,
        SWD   = 4'd8,
        JMP   = 4'd9,
        RTYPE = 4'd15
    } opcodeE;

    typedef enum logic [functW-1:0] {
        ADD = 6'd0,
        SUB = 6'd1,
        AND = 6'd2,
        ORR = 6'd3,
        NOT = 6'd4,
        TCP = 6'd5,
        SHL = 6'd6,
        SHR = 6'd7,
        WWD = 6'd28,
        HLT = 6'd29
    } functE;

endpackage

`default_nettype wire

/* cpuTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTop
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic [wordSize-1:0] instData,
    input  logic [wordSize-1:0] dataReadData,
    output logic                instRead,
    output logic [wordSize-1:0] instAddress,
    output logic                dataRead,
    output logic                dataWrite,
    output logic [wordSize-1:0] dataAddress,
    output logic [wordSize-1:0] dataWriteData,
    output logic [wordSize-1:0] numInst,
    output logic [wordSize-1:0] outputPort,
    output logic                outputValid,
    output logic                isHalted
);

    // decode outputs for the ID stage
    logic                regWrite, aluSrcImm, memRead, memWrite;
    logic                isBranch, isJump, isWwd, isHalt;
    logic                usesRs, usesRt;
    aluOpE               aluOp;
    wbSelE               wbSel;
    logic [regAddrW-1:0] destReg;
    logic [wordSize-1:0] idInstr;

    // hazard report and pipeline control
    logic [regAddrW-1:0] idRs, idRt, exDest;
    logic                idUsesRs, idUsesRt, idJump, idHalt, idValid;
    logic                exRegWrite, exBranchTaken, wbHalt, retire;
    logic                stall, flushIfId, flushIdEx, fetchStop, halted;

    assign instRead = !fetchStop;
    assign isHalted = halted;

    controlUnit u_controlUnit (
        .instr(idInstr),
        .*
    );

    pipeControl u_pipeControl (.*);

    retireCounter u_retireCounter (.*);

    datapath u_datapath (.*);

endmodule

`default_nettype wire

/* datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic [wordSize-1:0] instData,
    input  logic [wordSize-1:0] dataReadData,
    input  logic                regWrite,
    input  logic                aluSrcImm,
    input  logic                memRead,
    input  logic                memWrite,
    input  logic                isBranch,
    input  logic                isJump,
    input  logic                isWwd,
    input  logic                isHalt,
    input  logic                usesRs,
    input  logic                usesRt,
    input  aluOpE               aluOp,
    input  wbSelE               wbSel,
    input  logic [regAddrW-1:0] destReg,
    input  logic                stall,
    input  logic                flushIfId,
    input  logic                flushIdEx,
    input  logic                fetchStop,
    input  logic                halted,
    output logic [wordSize-1:0] instAddress,
    output logic [wordSize-1:0] dataAddress,
    output logic [wordSize-1:0] dataWriteData,
    output logic [wordSize-1:0] idInstr,
    output logic                dataRead,
    output logic                dataWrite,
    output logic [regAddrW-1:0] idRs,
    output logic [regAddrW-1:0] idRt,
    output logic                idUsesRs,
    output logic                idUsesRt,
    output logic                idJump,
    output logic                idHalt,
    output logic                idValid,
    output logic                exRegWrite,
    output logic [regAddrW-1:0] exDest,
    output logic                exBranchTaken,
    output logic                wbHalt,
    output logic                retire,
    output logic                outputValid,
    output logic [wordSize-1:0] outputPort
);

    logic [wordSize-1:0] pc, pcPlus1, ifIdPcPlus1;
    logic [wordSize-1:0] rsVal, rtVal, idImm, jumpTarget;
    logic [immW-1:0]     immField;
    opcodeE              idOpcode;

    logic                exValid, exRegWr, exAluSrcImm, exMemRead, exMemWrite;
    logic                exIsBranch, exIsWwd, exIsHalt;
    aluOpE               exAluOp;
    wbSelE               exWbSel;
    opcodeE              exOpcode;
    logic [wordSize-1:0] exRsVal, exRtVal, exImm, exPcPlus1;
    logic [wordSize-1:0] aluB, aluResult, exResult, branchTarget;
    logic                aluTaken;

    logic                wbValid, wbRegWr, wbIsWwd, wbIsHalt, wbWrite;
    logic [regAddrW-1:0] wbDest;
    logic [wordSize-1:0] wbData;

    assign pcPlus1      = pc + 1'b1;
    assign instAddress  = pc;
    assign branchTarget = exPcPlus1 + exImm;
    assign jumpTarget   = {ifIdPcPlus1[wordSize-1:targetW], idInstr[targetW-1:0]};

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (!halted) begin
            if (exBranchTaken) pc <= branchTarget;
            else if (flushIfId && !fetchStop) pc <= jumpTarget; // only a jump flushes here
            else if (!stall && !fetchStop) pc <= pcPlus1;
        end
    end

    // IF/ID
    always_ff @(posedge clk) begin
        if (reset) idValid <= 1'b0;
        else if (!halted && (flushIfId || fetchStop)) idValid <= 1'b0;
        else if (!halted && !stall) idValid <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!halted && !stall) begin
            idInstr     <= instData;
            ifIdPcPlus1 <= pcPlus1;
        end
    end

    assign idOpcode = opcodeE'(idInstr[opLsb +: opW]);
    assign immField = idInstr[immW-1:0];
    assign idImm    = (idOpcode == ORI) ? {{(wordSize-immW){1'b0}}, immField}
                                        : {{(wordSize-immW){immField[immW-1]}}, immField};
    assign idRs     = idInstr[rsLsb +: regAddrW];
    assign idRt     = idInstr[rtLsb +: regAddrW];
    assign idUsesRs = idValid && usesRs;
    assign idUsesRt = idValid && usesRt;
    assign idJump   = idValid && isJump;
    assign idHalt   = isHalt;

    regFile u_regFile (
        .clk(clk),
        .reset(reset),
        .readAddrA(idRs),
        .readAddrB(idRt),
        .writeAddr(wbDest),
        .writeData(wbData),
        .writeEnable(wbWrite),
        .readDataA(rsVal),
        .readDataB(rtVal)
    );

    // ID/EX, a stall or flush leaves a bubble
    always_ff @(posedge clk) begin
        if (reset) exValid <= 1'b0;
        else if (!halted) exValid <= idValid && !stall && !flushIdEx;
    end

    always_ff @(posedge clk) begin
        if (!halted) begin
            exRegWr     <= regWrite;
            exAluSrcImm <= aluSrcImm;
            exMemRead   <= memRead;
            exMemWrite  <= memWrite;
            exIsBranch  <= isBranch;
            exIsWwd     <= isWwd;
            exIsHalt    <= isHalt;
            exAluOp     <= aluOp;
            exWbSel     <= wbSel;
            exDest      <= destReg;
            exOpcode    <= idOpcode;
            exRsVal     <= rsVal;
            exRtVal     <= rtVal;
            exImm       <= idImm;
            exPcPlus1   <= ifIdPcPlus1;
        end
    end

    assign aluB = exAluSrcImm ? exImm : exRtVal;

    alu u_alu (
        .opA(exRsVal),
        .opB(aluB),
        .aluOp(exAluOp),
        .branchOp(exOpcode),
        .result(aluResult),
        .branchTaken(aluTaken)
    );

    assign exBranchTaken = exValid && exIsBranch && aluTaken;
    assign exRegWrite    = exValid && exRegWr;
    assign dataRead      = exValid && exMemRead;
    assign dataWrite     = exValid && exMemWrite;
    assign dataAddress   = aluResult; // rs + sign-extended imm
    assign dataWriteData = exRtVal;

    // memory answers in EX, so the write-back value is picked here
    assign exResult = exIsWwd ? exRsVal : ((exWbSel == WB_MEM) ? dataReadData : aluResult);

    // EX/WB
    always_ff @(posedge clk) begin
        if (reset) wbValid <= 1'b0;
        else if (!halted) wbValid <= exValid;
    end

    always_ff @(posedge clk) begin
        if (!halted) begin
            wbRegWr  <= exRegWr;
            wbIsWwd  <= exIsWwd;
            wbIsHalt <= exIsHalt;
            wbDest   <= exDest;
            wbData   <= exResult;
        end
    end

    assign wbWrite = wbValid && wbRegWr && !halted;
    assign retire  = wbValid && !halted; // HLT counts once
    assign wbHalt  = wbValid && wbIsHalt;

    always_ff @(posedge clk) begin
        if (reset) outputValid <= 1'b0;
        else outputValid <= wbValid && wbIsWwd && !halted;
    end

    always_ff @(posedge clk) begin
        if (wbValid && wbIsWwd && !halted) outputPort <= wbData;
    end

endmodule

`default_nettype wire

/* pipeControl.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeControl
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic [regAddrW-1:0] idRs,
    input  logic [regAddrW-1:0] idRt,
    input  logic                idUsesRs,
    input  logic                idUsesRt,
    input  logic                exRegWrite,
    input  logic [regAddrW-1:0] exDest,
    input  logic                exBranchTaken,
    input  logic                idJump,
    input  logic                idHalt,
    input  logic                idValid,
    input  logic                wbHalt,
    output logic                stall,
    output logic                flushIfId,
    output logic                flushIdEx,
    output logic                fetchStop,
    output logic                halted
);

    pipeStateE state;
    pipeStateE nextState;
    logic      hazard;

    // raw hazard against the writer in EX, WB is covered by the bypass
    assign hazard = exRegWrite &&
                    ((idUsesRs && idRs == exDest) || (idUsesRt && idRt == exDest));
    assign halted = (state == HALTED);

    always_comb begin
        nextState = state;
        stall     = 1'b0;
        flushIfId = 1'b0;
        flushIdEx = 1'b0;
        fetchStop = 1'b0;
        case (state)
            RUN: begin
                flushIdEx = exBranchTaken;
                flushIfId = exBranchTaken || idJump;
                stall     = hazard && !exBranchTaken; // branch flush wins
                if (idValid && idHalt && !stall && !exBranchTaken) nextState = DRAIN;
            end
            DRAIN: begin
                fetchStop = 1'b1;
                flushIfId = 1'b1;
                flushIdEx = 1'b1;
                if (exBranchTaken) nextState = RUN; // older branch still redirects
                else if (wbHalt) nextState = HALTED;
            end
            default: fetchStop = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) state <= RUN;
        else state <= nextState;
    end

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile
    import cpuIsaPkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic [regAddrW-1:0] readAddrA,
    input  logic [regAddrW-1:0] readAddrB,
    input  logic [regAddrW-1:0] writeAddr,
    input  logic [wordSize-1:0] writeData,
    input  logic                writeEnable,
    output logic [wordSize-1:0] readDataA,
    output logic [wordSize-1:0] readDataB
);

    logic [wordSize-1:0] regs [numRegs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

    // write-first so WB results reach ID in the same cycle
    assign readDataA = (writeEnable && writeAddr == readAddrA) ? writeData : regs[readAddrA];
    assign readDataB = (writeEnable && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

`default_nettype wire

/* retireCounter.sv */
`timescale 1ns/1ps
`default_nettype none

module retireCounter
    import cpuIsaPkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                retire,
    output logic [wordSize-1:0] numInst
);

    always_ff @(posedge clk) begin
        if (reset) numInst <= '0;
        else if (retire) numInst <= numInst + 1'b1; // wraps
    end

endmodule

`default_nettype wire

/* sources.f */
cpuIsaPkg.sv
cpuCtrlPkg.sv
controlUnit.sv
pipeControl.sv
retireCounter.sv
regFile.sv
alu.sv
datapath.sv
cpuTop.sv
tb_clockGen.sv
tb_cpuTop.sv

/* tb_clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clockGen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* tb_cpuTop.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpuTop
    import cpuIsaPkg::*;
();

    logic        clk, genReset, reset;
    logic        tbReset = 1'b0;
    logic [15:0] instData, dataReadData, instAddress, dataAddress, dataWriteData;
    logic [15:0] numInst, outputPort;
    logic        instRead, dataRead, dataWrite, outputValid, isHalted;

    logic [15:0] imem [0:255];
    logic [15:0] dmem [0:65535];
    logic [15:0] refMem [0:65535];
    logic [15:0] expQ [$];
    int          expCount;
    int          fillPtr;
    logic        haltWatch = 1'b0;

    tb_clockGen u_clockGen (.clk(clk), .reset(genReset));

    assign reset = genReset | tbReset;
    assign instData = imem[instAddress[7:0]]; // combinational memories
    assign dataReadData = dmem[dataAddress];

    cpuTop u_cpuTop (.*);

    always @(posedge clk) begin
        if (dataWrite) dmem[dataAddress] <= dataWriteData;
    end

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("Fail at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    // compare process
    always @(posedge clk) begin
        if (outputValid) begin
            if (expQ.size() == 0) abortRun("an outputValid pulse came with no WWD expected");
            else check("outputPort", outputPort, expQ.pop_front());
        end
        if (haltWatch && dataWrite) abortRun("a data write happened after halt");
        if (dataRead && dataWrite) abortRun("the data read and write strobes were high together");
    end

    function automatic logic [15:0] rType(input int rs, rt, rd, input logic [5:0] f);
        return {4'hF, rs[1:0], rt[1:0], rd[1:0], f};
    endfunction

    function automatic logic [15:0] iType(input logic [3:0] op, input int rs, rt,
                                          input logic [7:0] imm);
        return {op, rs[1:0], rt[1:0], imm};
    endfunction

    task automatic put(input logic [15:0] instr);
        imem[fillPtr] = instr;
        fillPtr++;
    endtask

    // ISA interpreter over imem and refMem
    function automatic void runRef();
        logic [15:0] regs [4];
        logic [15:0] pc, instr, rs, rt, sImm, zImm, pc1;
        int rsI, rtI, rdI;
        for (int i = 0; i < 4; i++) regs[i] = '0;
        pc = '0;
        expCount = 0;
        for (int step = 0; step < 10000; step++) begin
            instr = imem[pc[7:0]];
            rsI = instr[11:10];
            rtI = instr[9:8];
            rdI = instr[7:6];
            rs = regs[rsI];
            rt = regs[rtI];
            sImm = {{8{instr[7]}}, instr[7:0]};
            zImm = {8'h00, instr[7:0]};
            pc1 = pc + 16'd1;
            pc = pc1;
            expCount++;
            case (instr[15:12])
                ADI: regs[rtI] = rs + sImm;
                ORI: regs[rtI] = rs | zImm;
                LHI: regs[rtI] = {instr[7:0], 8'h00};
                LWD: regs[rtI] = refMem[rs + sImm];
                SWD: refMem[rs + sImm] = rt;
                BNE: if (rs != rt) pc = pc1 + sImm;
                BEQ: if (rs == rt) pc = pc1 + sImm;
                BGZ: if (!rs[15] && rs != 0) pc = pc1 + sImm;
                BLZ: if (rs[15]) pc = pc1 + sImm;
                JMP: pc = {pc1[15:12], instr[11:0]};
                4'hF: begin
                    case (instr[5:0])
                        ADD: regs[rdI] = rs + rt;
                        SUB: regs[rdI] = rs - rt;
                        AND: regs[rdI] = rs & rt;
                        ORR: regs[rdI] = rs | rt;
                        NOT: regs[rdI] = ~rs;
                        TCP: regs[rdI] = 16'd0 - rs;
                        SHL: regs[rdI] = rs << 1;
                        SHR: regs[rdI] = $signed(rs) >>> 1;
                        WWD: expQ.push_back(rs);
                        HLT: return;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    endfunction

    task automatic loadProgram(input int id);
        logic [7:0] offset;
        for (int i = 0; i < 256; i++) imem[i] = rType(0, 0, 0, HLT); // stray fetch halts
        fillPtr = 0;
        case (id)
            0: begin // arithmetic and logic
                put(iType(LHI, 0, 0, 8'($urandom)));
                put(iType(ORI, 0, 0, 8'($urandom)));
                put(iType(LHI, 0, 1, 8'($urandom)));
                put(iType(ORI, 1, 1, 8'($urandom)));
                for (int f = 0; f < 8; f++) begin
                    put(rType(0, 1, 2, 6'(f)));
                    put(rType(2, 0, 0, WWD));
                end
                put(iType(ADI, 0, 3, 8'($urandom)));
                put(iType(ORI, 3, 3, 8'($urandom)));
                put(rType(3, 0, 0, WWD));
            end
            1: begin // load and store
                offset = 8'($urandom % 16);
                put(iType(LHI, 0, 0, 8'h00));
                put(iType(ORI, 0, 0, 8'($urandom)));
                put(iType(LHI, 0, 1, 8'($urandom)));
                put(iType(ORI, 1, 1, 8'($urandom)));
                put(iType(SWD, 0, 1, offset));
                put(iType(LWD, 0, 2, offset));
                put(rType(2, 0, 0, WWD));
                put(iType(LWD, 0, 3, 8'($urandom)));
                put(rType(3, 0, 0, WWD));
                put(iType(SWD, 0, 3, 8'h05));
                put(iType(LWD, 0, 2, 8'h05));
                put(rType(2, 0, 0, WWD));
            end
            2: begin // dependencies at distance 1, 2 and 3
                put(iType(LHI, 0, 0, 8'($urandom)));
                put(iType(ORI, 0, 0, 8'($urandom)));
                put(rType(0, 0, 1, ADD));
                put(rType(1, 0, 2, SUB));
                put(rType(2, 0, 0, WWD));
                put(iType(ADI, 1, 3, 8'($urandom)));
                put(iType(LHI, 0, 2, 8'h12));
                put(rType(3, 0, 0, WWD));
                put(rType(3, 2, 3, ADD));
                put(rType(3, 0, 0, WWD));
            end
            default: begin // branches and jump
                put(iType(LHI, 0, 0, 8'h00));
                put(iType(ADI, 0, 0, 8'h05));
                put(iType(LHI, 0, 1, 8'hFF));
                put(iType(BEQ, 0, 0, 8'h02));
                put(rType(1, 0, 0, WWD)); // flushed slots
                put(iType(SWD, 0, 1, 8'h00));
                put(rType(0, 0, 0, WWD));
                put(iType(BNE, 0, 0, 8'h02));
                put(rType(0, 0, 0, WWD));
                put(iType(BGZ, 0, 0, 8'h01));
                put(iType(SWD, 0, 1, 8'h01));
                put(iType(BLZ, 1, 0, 8'h01));
                put(rType(1, 0, 0, WWD));
                put(iType(BLZ, 0, 0, 8'h05));
                put(iType(BGZ, 1, 0, 8'h05));
                put({JMP, 12'd18});
                put(rType(1, 0, 0, WWD));
                put(iType(SWD, 0, 1, 8'h02));
                put(iType(SWD, 0, 0, 8'h03));
                put(rType(1, 0, 0, WWD));
                put(iType(BEQ, 0, 1, 8'h01));
                put(iType(BNE, 0, 1, 8'h01));
                put(iType(SWD, 0, 1, 8'h04)); // flushed by the taken bne
            end
        endcase
        put(rType(0, 0, 0, HLT));
    endtask

    task automatic runProgram(input int id);
        int cycles;
        haltWatch = 1'b0;
        @(posedge clk);
        tbReset <= 1'b1;
        loadProgram(id);
        for (int a = 0; a < 65536; a++) begin
            dmem[a] = 16'($urandom);
            refMem[a] = dmem[a];
        end
        expQ.delete();
        runRef();
        repeat (3) @(posedge clk);
        tbReset <= 1'b0;
        @(negedge clk);
        check("numInst", numInst, 16'd0);
        check("isHalted", {15'd0, isHalted}, 16'd0);
        check("instRead", {15'd0, instRead}, 16'd1);
        check("dataRead", {15'd0, dataRead}, 16'd0);
        check("dataWrite", {15'd0, dataWrite}, 16'd0);
        check("outputValid", {15'd0, outputValid}, 16'd0);
        cycles = 0;
        while (!isHalted) begin
            @(posedge clk);
            cycles++;
            if (cycles > 2000) abortRun($sformatf("program %0d never halted", id));
        end
        haltWatch = 1'b1;
        for (int c = 0; c < 20; c++) begin
            @(posedge clk);
            check("isHalted", {15'd0, isHalted}, 16'd1);
            check("instRead", {15'd0, instRead}, 16'd0); // fetch stays stopped
            check("dataRead", {15'd0, dataRead}, 16'd0);
        end
        check("numInst", numInst, 16'(expCount));
        if (expQ.size() != 0) abortRun($sformatf("%0d WWD values are missing", expQ.size()));
        for (int a = 0; a < 65536; a++) check("dataMemory", dmem[a], refMem[a]);
    endtask

    initial begin
        int unsigned seedVal;
        int waitCycles;
        seedVal = 26128;
        void'($urandom(seedVal));
        for (int i = 0; i < 256; i++) imem[i] = '0;
        waitCycles = 0;
        while (genReset !== 1'b0) begin
            @(posedge clk);
            waitCycles++;
            if (waitCycles > 20) abortRun("the initial reset never ended");
        end
        for (int p = 0; p < 4; p++) runProgram(p);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire
